// ==== logic/cpu_consts.svh ====
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// reset vector, low byte at FFFC and high byte at FFFD
`define CPU_RST_VECTOR 16'hFFFC

// flag bit positions in p
`define CPU_FL_C 0
`define CPU_FL_Z 1
`define CPU_FL_I 2
`define CPU_FL_V 6
`define CPU_FL_N 7
`define CPU_FL_I_RESET (8'h01 << `CPU_FL_I)  // irq masked out of reset

// opcode layout aaa_bbb_cc
`define CPU_OP_AAA 7:5
`define CPU_OP_BBB 4:2
`define CPU_OP_CC  1:0
`define CPU_OP_JMP_ABS 8'h4C

`endif

// ==== logic/cpu_pkg.sv ====
package cpu_pkg;

    // sequencer states
    typedef enum logic [3:0] {
        T_BOOT, T_BOOT_HI, T0_FETCH, T1_DECODE, T2_ZPG,
        T2_ABS, T3_ABS, T2_JUMP, T3_JUMP, T_JAM
    } state_e;

    // source of one address byte
    typedef enum logic [2:0] {
        ADDR_PC, ADDR_DATA, ADDR_ADD, ADDR_ZERO, ADDR_VEC, ADDR_HOLD
    } addr_src_e;

    typedef enum logic [2:0] {SB_A, SB_X, SB_Y, SB_ADD, SB_DATA, SB_ZERO} sb_src_e;
    typedef enum logic [1:0] {DB_DATA, DB_SB, DB_P, DB_ZERO} db_src_e;
    typedef enum logic [2:0] {DST_NONE, DST_A, DST_X, DST_Y, DST_MEM} dst_e;
    typedef enum logic [2:0] {ALU_ADD, ALU_AND, ALU_OR, ALU_EOR, ALU_NOP} alu_op_e;

    // one decoded instruction
    typedef struct packed {
        alu_op_e    alu_op;
        logic       ai_inv;
        logic       bi_inv;
        logic [1:0] carry_in;    // 00 zero, 01 one, 1x from p.c
        sb_src_e    sb_src;
        db_src_e    db_src;
        dst_e       dst;
        logic       single_byte;
        logic       rd;          // computes in the fetch cycle after its operand
        logic       st;          // writes memory in its last cycle
        logic [7:0] alu_mask;
        logic [7:0] set_mask;
        logic [7:0] clear_mask;
    } op_ctrl_t;

    // control for one cycle of the datapath
    typedef struct packed {
        addr_src_e  adl_src;
        addr_src_e  adh_src;
        logic       inc_pc;
        logic       jump;        // pc <= addr + 1
        logic       hold_alu;
        sb_src_e    sb_src;
        db_src_e    db_src;
        logic       we_a;
        logic       we_x;
        logic       we_y;
        logic       we_p;
        logic       db_write;
        alu_op_e    alu_op;
        logic       ai_inv;
        logic       bi_inv;
        logic       ci;
        logic [7:0] alu_mask;
        logic [7:0] set_mask;
        logic [7:0] clear_mask;
    } ctrl_word_t;

endpackage

// ==== logic/cpu_decode.sv ====
`timescale 1ns/10ps
`include "cpu_consts.svh"

module cpu_decode (
    input  logic [7:0]        i_opcode,
    output cpu_pkg::op_ctrl_t o_op,
    output cpu_pkg::state_e   o_initial_state
);
    import cpu_pkg::*;

    localparam logic [7:0] M_C    = 8'h01 << `CPU_FL_C;
    localparam logic [7:0] M_NZ   = (8'h01 << `CPU_FL_N) | (8'h01 << `CPU_FL_Z);
    localparam logic [7:0] M_NZC  = M_NZ | M_C;
    localparam logic [7:0] M_NZVC = M_NZC | (8'h01 << `CPU_FL_V);

    logic [2:0] aaa;
    logic [2:0] bbb;
    logic [1:0] cc;
    logic       imm_mode;
    logic       impl;
    state_e     mem_state;

    assign aaa = i_opcode[`CPU_OP_AAA];
    assign bbb = i_opcode[`CPU_OP_BBB];
    assign cc  = i_opcode[`CPU_OP_CC];

    // addressing mode from bbb, immediate sits at a different bbb in group 01
    always_comb begin
        imm_mode = (cc == 2'b01) ? (bbb == 3'b010) : (bbb == 3'b000);
        case (bbb)
            3'b001:  mem_state = T2_ZPG;
            3'b011:  mem_state = T2_ABS;
            default: mem_state = imm_mode ? T0_FETCH : T_JAM;
        endcase
    end

    always_comb begin
        o_op = '0;
        o_op.alu_op = ALU_NOP;
        o_initial_state = T_JAM;
        impl = 1'b1;
        case (i_opcode)
            8'hea: impl = 1'b1;                                   // nop
            8'h18: o_op.clear_mask = M_C;                         // clc
            8'h38: o_op.set_mask = M_C;                           // sec
            8'haa, 8'ha8: begin                                   // tax, tay
                o_op.dst = i_opcode[1] ? DST_X : DST_Y;
                o_op.alu_mask = M_NZ;
            end
            8'h8a, 8'h98: begin                                   // txa, tya
                o_op.sb_src = i_opcode[1] ? SB_X : SB_Y;
                o_op.dst = DST_A;
                o_op.alu_mask = M_NZ;
            end
            8'he8, 8'hc8, 8'hca, 8'h88: begin                     // inx, iny, dex, dey
                // e8 and ca work on x
                o_op.sb_src = (i_opcode[5] | i_opcode[1]) ? SB_X : SB_Y;
                o_op.dst = (i_opcode[5] | i_opcode[1]) ? DST_X : DST_Y;
                o_op.db_src = DB_ZERO;
                o_op.alu_op = ALU_ADD;
                o_op.bi_inv = i_opcode[1] | ~i_opcode[6];         // dec adds ff
                o_op.carry_in = {1'b0, i_opcode[6] & ~i_opcode[1]};
                o_op.alu_mask = M_NZ;
            end
            `CPU_OP_JMP_ABS: begin
                impl = 1'b0;
                o_initial_state = T2_JUMP;
            end
            default: begin
                impl = 1'b0;
                if (cc == 2'b01) begin                            // alu group on a
                    o_initial_state = mem_state;
                    o_op.rd = 1'b1;
                    o_op.dst = DST_A;
                    o_op.alu_mask = M_NZ;
                    case (aaa)
                        3'b000: o_op.alu_op = ALU_OR;
                        3'b001: o_op.alu_op = ALU_AND;
                        3'b010: o_op.alu_op = ALU_EOR;
                        3'b011: begin                             // adc
                            o_op.alu_op = ALU_ADD;
                            o_op.carry_in = 2'b10;
                            o_op.alu_mask = M_NZVC;
                        end
                        3'b100: begin                             // sta
                            o_op.rd = 1'b0;
                            o_op.st = 1'b1;
                            o_op.dst = DST_MEM;
                            o_op.alu_mask = 8'h00;
                            if (imm_mode) o_initial_state = T_JAM;
                        end
                        3'b101: o_op.sb_src = SB_DATA;            // lda
                        3'b110: begin                             // cmp, a - m
                            o_op.alu_op = ALU_ADD;
                            o_op.bi_inv = 1'b1;
                            o_op.carry_in = 2'b01;
                            o_op.dst = DST_NONE;
                            o_op.alu_mask = M_NZC;
                        end
                        default: begin                            // sbc
                            o_op.alu_op = ALU_ADD;
                            o_op.bi_inv = 1'b1;
                            o_op.carry_in = 2'b10;
                            o_op.alu_mask = M_NZVC;
                        end
                    endcase
                end else if (cc != 2'b11 && aaa[2:1] == 2'b10) begin
                    o_initial_state = mem_state;                  // ldx/stx, ldy/sty
                    o_op.sb_src = cc[1] ? SB_X : SB_Y;
                    if (aaa[0]) begin
                        o_op.sb_src = SB_DATA;
                        o_op.rd = 1'b1;
                        o_op.dst = cc[1] ? DST_X : DST_Y;
                        o_op.alu_mask = M_NZ;
                    end else begin
                        o_op.st = 1'b1;
                        o_op.dst = DST_MEM;
                        if (imm_mode) o_initial_state = T_JAM;
                    end
                end
            end
        endcase
        if (impl) begin
            o_op.single_byte = 1'b1;
            o_op.rd = 1'b1;
            o_initial_state = T0_FETCH;
        end
    end

endmodule

// ==== logic/cpu_sequencer.sv ====
`timescale 1ns/10ps
`include "cpu_consts.svh"

module cpu_sequencer (
    input  logic                i_clk,
    input  logic                i_rst,
    input  logic [7:0]          i_data,
    input  logic [7:0]          i_p,
    output cpu_pkg::ctrl_word_t o_ctrl,
    output logic                o_rw,
    output logic                o_sync,
    output logic                o_jam
);
    import cpu_pkg::*;

    state_e     state;
    state_e     next_state;
    state_e     new_state;
    logic [7:0] ir;
    op_ctrl_t   op;       // instruction held in ir
    op_ctrl_t   new_op;   // opcode arriving during decode
    ctrl_word_t c;
    logic       exec;
    logic       save;

    cpu_decode u_dec_ir (
        .i_opcode        (ir),
        .o_op            (op),
        .o_initial_state ()
    );

    cpu_decode u_dec_new (
        .i_opcode        (i_data),
        .o_op            (new_op),
        .o_initial_state (new_state)
    );

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state <= T_BOOT;
            ir    <= `CPU_OP_JMP_ABS;  // boot behaves as the tail of a jmp
        end else begin
            state <= next_state;
            if (state == T1_DECODE) ir <= i_data;
        end
    end

    always_comb begin
        c = '0;
        c.sb_src = SB_ZERO;   // idle alu passes db into add
        exec = 1'b0;
        save = 1'b0;
        o_sync = 1'b0;
        o_jam = 1'b0;
        next_state = state;
        case (state)
            T_BOOT: begin
                c.adl_src = ADDR_VEC;
                c.adh_src = ADDR_VEC;
                c.jump = 1'b1;
                next_state = T_BOOT_HI;
            end
            T_BOOT_HI, T2_JUMP: begin   // low target byte lands in add
                c.inc_pc = 1'b1;
                next_state = T3_JUMP;
            end
            T2_ABS: begin
                c.inc_pc = 1'b1;
                next_state = T3_ABS;
            end
            T0_FETCH: begin
                o_sync = 1'b1;
                c.inc_pc = 1'b1;
                exec = op.rd;           // operand of previous instr is on i_data
                next_state = T1_DECODE;
            end
            T1_DECODE: begin
                c.inc_pc = !new_op.single_byte;
                save = op.rd;           // ir still holds the previous instr
                next_state = new_state;
            end
            T2_ZPG: begin
                c.adl_src = ADDR_DATA;
                c.adh_src = ADDR_ZERO;
                save = op.st;
                next_state = T0_FETCH;
            end
            T3_ABS: begin
                c.adl_src = ADDR_ADD;
                c.adh_src = ADDR_DATA;
                save = op.st;
                next_state = T0_FETCH;
            end
            T3_JUMP: begin              // target fetch doubles as opcode fetch
                c.adl_src = ADDR_ADD;
                c.adh_src = ADDR_DATA;
                c.jump = 1'b1;
                o_sync = 1'b1;
                next_state = T1_DECODE;
            end
            default: begin
                o_jam = 1'b1;
                c.hold_alu = 1'b1;
                c.adl_src = ADDR_HOLD;
                c.adh_src = ADDR_HOLD;
                next_state = T_JAM;
            end
        endcase

        if (exec) begin
            c.alu_op = op.alu_op;
            c.ai_inv = op.ai_inv;
            c.bi_inv = op.bi_inv;
            c.ci = op.carry_in[1] ? i_p[`CPU_FL_C] : op.carry_in[0];
            c.alu_mask = op.alu_mask;
            c.set_mask = op.set_mask;
            c.clear_mask = op.clear_mask;
            c.sb_src = op.sb_src;
            c.db_src = op.db_src;
            c.we_p = 1'b1;
        end

        if (save) begin
            c.sb_src = (op.dst == DST_MEM) ? op.sb_src : SB_ADD;
            c.db_src = DB_SB;
            c.db_write = (op.dst == DST_MEM);
            c.we_a = (op.dst == DST_A);
            c.we_x = (op.dst == DST_X);
            c.we_y = (op.dst == DST_Y);
        end
    end

    assign o_ctrl = c;
    assign o_rw = !c.db_write;

endmodule

// ==== logic/cpu_regfile.sv ====
`timescale 1ns/10ps
`include "cpu_consts.svh"

module cpu_regfile (
    input  logic                i_clk,
    input  logic                i_rst,
    input  cpu_pkg::ctrl_word_t i_ctrl,
    input  logic [7:0]          i_data,
    input  logic [7:0]          i_add,
    input  logic [7:0]          i_alu_status,
    output logic [7:0]          o_sb,
    output logic [7:0]          o_db,
    output logic [7:0]          o_p
);
    import cpu_pkg::*;

    logic [7:0] a;
    logic [7:0] x;
    logic [7:0] y;
    logic [7:0] p;

    always_comb begin
        case (i_ctrl.sb_src)
            SB_A:    o_sb = a;
            SB_X:    o_sb = x;
            SB_Y:    o_sb = y;
            SB_ADD:  o_sb = i_add;
            SB_DATA: o_sb = i_data;
            default: o_sb = 8'h00;
        endcase
        case (i_ctrl.db_src)
            DB_DATA: o_db = i_data;
            DB_SB:   o_db = o_sb;   // store path to memory
            DB_P:    o_db = p;
            default: o_db = 8'h00;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            a <= 8'h00;
            x <= 8'h00;
            y <= 8'h00;
            p <= `CPU_FL_I_RESET;
        end else begin
            if (i_ctrl.we_a) a <= o_sb;
            if (i_ctrl.we_x) x <= o_sb;
            if (i_ctrl.we_y) y <= o_sb;
            // masked alu flags, then explicit set and clear
            if (i_ctrl.we_p) begin
                p <= ~i_ctrl.clear_mask & (i_ctrl.set_mask
                     | (i_ctrl.alu_mask & i_alu_status) | (~i_ctrl.alu_mask & p));
            end
        end
    end

    assign o_p = p;

endmodule

// ==== logic/cpu_alu.sv ====
`timescale 1ns/10ps
`include "cpu_consts.svh"

module cpu_alu (
    input  logic                i_clk,
    input  logic                i_rst,
    input  cpu_pkg::ctrl_word_t i_ctrl,
    input  logic [7:0]          i_sb,
    input  logic [7:0]          i_db,
    output logic [7:0]          o_add,
    output logic [7:0]          o_status
);
    import cpu_pkg::*;

    logic [7:0] ai;
    logic [7:0] bi;
    logic [7:0] res;
    logic [8:0] sum;

    assign ai  = i_ctrl.ai_inv ? ~i_sb : i_sb;
    assign bi  = i_ctrl.bi_inv ? ~i_db : i_db;   // subtract as a + ~b + c
    assign sum = {1'b0, ai} + {1'b0, bi} + {8'd0, i_ctrl.ci};

    always_comb begin
        case (i_ctrl.alu_op)
            ALU_ADD: res = sum[7:0];
            ALU_AND: res = ai & bi;
            ALU_OR:  res = ai | bi;
            ALU_EOR: res = ai ^ bi;
            default: res = ai;       // pass sb through
        endcase
        o_status = 8'h00;
        o_status[`CPU_FL_N] = res[7];
        o_status[`CPU_FL_V] = (ai[7] == bi[7]) && (sum[7] != ai[7]);
        o_status[`CPU_FL_Z] = (res == 8'h00);
        o_status[`CPU_FL_C] = sum[8];
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_add <= 8'h00;
        end else if (!i_ctrl.hold_alu) begin
            o_add <= res;
        end
    end

endmodule

// ==== logic/cpu_addr_gen.sv ====
`timescale 1ns/10ps
`include "cpu_consts.svh"

module cpu_addr_gen (
    input  logic                i_clk,
    input  logic                i_rst,
    input  cpu_pkg::ctrl_word_t i_ctrl,
    input  logic [7:0]          i_data,
    input  logic [7:0]          i_add,
    output logic [15:0]         o_addr
);
    import cpu_pkg::*;

    localparam logic [15:0] RST_VEC = `CPU_RST_VECTOR;

    logic [15:0] pc;
    logic [7:0]  adl_q;
    logic [7:0]  adh_q;

    // one address byte, same choices for both halves
    function automatic logic [7:0] pick(addr_src_e src, logic [7:0] pc_b,
                                        logic [7:0] vec_b, logic [7:0] hold_b);
        case (src)
            ADDR_PC:   pick = pc_b;
            ADDR_DATA: pick = i_data;
            ADDR_ADD:  pick = i_add;
            ADDR_ZERO: pick = 8'h00;
            ADDR_VEC:  pick = vec_b;
            default:   pick = hold_b;
        endcase
    endfunction

    always_comb begin
        o_addr[7:0]  = pick(i_ctrl.adl_src, pc[7:0], RST_VEC[7:0], adl_q);
        o_addr[15:8] = pick(i_ctrl.adh_src, pc[15:8], RST_VEC[15:8], adh_q);
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            pc <= RST_VEC;
        end else if (i_ctrl.jump) begin
            pc <= o_addr + 16'd1;   // target byte is fetched now, continue after it
        end else if (i_ctrl.inc_pc) begin
            pc <= pc + 16'd1;
        end
    end

    always_ff @(posedge i_clk) begin
        adl_q <= o_addr[7:0];
        adh_q <= o_addr[15:8];
    end

endmodule

// ==== logic/cpu_core.sv ====
`timescale 1ns/10ps

module cpu_core (
    input  logic        i_clk,
    input  logic        i_rst,
    input  logic [7:0]  i_data,
    output logic [15:0] o_addr,
    output logic [7:0]  o_dout,
    output logic        o_rw,
    output logic        o_sync,
    output logic        o_jam
);
    import cpu_pkg::*;

    ctrl_word_t ctrl;
    logic [7:0] sb;
    logic [7:0] db;
    logic [7:0] p;
    logic [7:0] add;
    logic [7:0] alu_status;

    cpu_sequencer u_seq (
        .i_clk  (i_clk),
        .i_rst  (i_rst),
        .i_data (i_data),
        .i_p    (p),
        .o_ctrl (ctrl),
        .o_rw   (o_rw),
        .o_sync (o_sync),
        .o_jam  (o_jam)
    );

    cpu_addr_gen u_addr (
        .i_clk  (i_clk),
        .i_rst  (i_rst),
        .i_ctrl (ctrl),
        .i_data (i_data),
        .i_add  (add),
        .o_addr (o_addr)
    );

    cpu_regfile u_regs (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_ctrl       (ctrl),
        .i_data       (i_data),
        .i_add        (add),
        .i_alu_status (alu_status),
        .o_sb         (sb),
        .o_db         (db),
        .o_p          (p)
    );

    cpu_alu u_alu (
        .i_clk    (i_clk),
        .i_rst    (i_rst),
        .i_ctrl   (ctrl),
        .i_sb     (sb),
        .i_db     (db),
        .o_add    (add),
        .o_status (alu_status)
    );

    assign o_dout = db;   // store data rides on db

endmodule

// ==== test/cpu_sva.sv ====
`timescale 1ns/10ps

module cpu_sva (
    input logic i_clk,
    input logic i_rst,
    input logic i_sync,
    input logic i_rw,
    input logic i_jam
);

    int err_count = 0;

    // opcode fetch is always a read
    sync_is_read: assert property (@(posedge i_clk) disable iff (i_rst)
        i_sync |-> i_rw)
        else begin
            $error("write strobe during opcode fetch");
            err_count++;
        end

    // shortest instruction is two cycles
    sync_not_back_to_back: assert property (@(posedge i_clk) disable iff (i_rst)
        i_sync |=> !i_sync)
        else begin
            $error("sync high in two consecutive cycles");
            err_count++;
        end

    jam_sticky: assert property (@(posedge i_clk) disable iff (i_rst)
        i_jam |=> i_jam)
        else begin
            $error("jam dropped before reset");
            err_count++;
        end

    jam_is_quiet: assert property (@(posedge i_clk) disable iff (i_rst)
        i_jam |-> (i_rw && !i_sync))   // no fetch and no write once jammed
        else begin
            $error("bus activity while jammed");
            err_count++;
        end

endmodule

bind cpu_core cpu_sva u_sva (
    .i_clk  (i_clk),
    .i_rst  (i_rst),
    .i_sync (o_sync),
    .i_rw   (o_rw),
    .i_jam  (o_jam)
);

// ==== test/tb_cpu.sv ====
`timescale 1ns/10ps
`include "cpu_consts.svh"

module tb_cpu;

    localparam logic [31:0] SEED = 32'h71d3_60e5;
    localparam logic [15:0] PROG_BASE = 16'h0400;
    localparam int N_INSTR = 40;
    localparam int N_GROUPS = N_INSTR / 5;
    localparam int MAX_CYCLES = N_INSTR * 4 + 20;
    localparam int JAM_HOLD = 6;        // cycles watched once jam is up

    // opcode pools, index 0 is the last byte listed
    localparam logic [44*8-1:0] ANY_OPS = {
        8'hA9, 8'hA2, 8'hA0, 8'h09, 8'h29, 8'h49, 8'h69, 8'hC9, 8'hE9,
        8'hA5, 8'hA6, 8'hA4, 8'h05, 8'h25, 8'h45, 8'h65, 8'hC5, 8'hE5, 8'h85, 8'h86, 8'h84,
        8'hAD, 8'hAE, 8'hAC, 8'h0D, 8'h2D, 8'h4D, 8'h6D, 8'hCD, 8'hED, 8'h8D, 8'h8E, 8'h8C,
        8'hE8, 8'hC8, 8'hCA, 8'h88, 8'hAA, 8'h8A, 8'hA8, 8'h98, 8'h18, 8'h38, 8'hEA
    };
    localparam logic [9*8-1:0] ARITH_OPS = {   // indices 0 to 5 are sbc and adc
        8'hC9, 8'hC5, 8'hCD, 8'h69, 8'h65, 8'h6D, 8'hE9, 8'hE5, 8'hED
    };
    localparam logic [6*8-1:0] STORE_OPS = {8'h85, 8'h86, 8'h84, 8'h8D, 8'h8E, 8'h8C};

    logic        i_clk = 1'b0;
    logic        i_rst;
    logic [7:0]  i_data;
    logic [15:0] o_addr;
    logic [7:0]  o_dout;
    logic        o_rw;
    logic        o_sync;
    logic        o_jam;

    logic [7:0]  mem [0:65535];
    logic [7:0]  ref_mem [0:65535];   // memory as the model sees it
    logic [31:0] lfsr;

    logic [7:0]  m_a;
    logic [7:0]  m_x;
    logic [7:0]  m_y;
    logic        m_c;
    logic [15:0] m_pc;
    logic        wr_pending = 1'b0;
    logic [15:0] wr_addr;
    logic [7:0]  wr_data;
    logic        jam_expected = 1'b0;
    logic        seen_sync = 1'b0;
    int          cycles = 0;
    int          boot_cyc = 0;
    int          gap = 0;
    int          exp_gap = 0;
    int          jam_cycles = 0;

    cpu_core DUT (
        .i_clk  (i_clk),
        .i_rst  (i_rst),
        .i_data (i_data),
        .o_addr (o_addr),
        .o_dout (o_dout),
        .o_rw   (o_rw),
        .o_sync (o_sync),
        .o_jam  (o_jam)
    );

    always #2 i_clk = ~i_clk;

    // memory answers one cycle after the address
    always @(posedge i_clk) begin
        i_data <= mem[o_addr];
        if (o_rw === 1'b0) mem[o_addr] <= o_dout;
    end

    // galois step, taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        lfsr_step = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [7:0] take_bits(input int n);
        logic [7:0] v;
        int         i;
        v = 8'h00;
        for (i = 0; i < n; i++) begin
            v = {v[6:0], lfsr[0]};
            lfsr = lfsr_step(lfsr);
        end
        take_bits = v;
    endfunction

    function automatic logic [7:0] fill_byte(input logic [15:0] a);
        fill_byte = a[7:0] ^ (a[15:8] * 8'd29);
    endfunction

    // 0 implied, 1 immediate, 2 zero page, 3 absolute
    function automatic int addr_mode(input logic [7:0] op);
        case (op)
            8'hA9, 8'hA2, 8'hA0, 8'h09, 8'h29, 8'h49, 8'h69, 8'hC9, 8'hE9: addr_mode = 1;
            8'hA5, 8'hA6, 8'hA4, 8'h05, 8'h25, 8'h45, 8'h65, 8'hC5, 8'hE5,
            8'h85, 8'h86, 8'h84: addr_mode = 2;
            8'hAD, 8'hAE, 8'hAC, 8'h0D, 8'h2D, 8'h4D, 8'h6D, 8'hCD, 8'hED,
            8'h8D, 8'h8E, 8'h8C, 8'h4C: addr_mode = 3;
            default: addr_mode = 0;
        endcase
    endfunction

    task automatic compare_value(input string name, input logic [15:0] exp,
                                 input logic [15:0] act);
        assert (act === exp) else begin
            $display("Fail %s expected %h actual %h", name, exp, act);
            $display("sim failed");
            $fatal(1);
        end
    endtask

    task automatic require_true(input logic cond, input string what);
        assert (cond === 1'b1) else begin
            $display("%s", what);
            $display("sim failed");
            $fatal(1);
        end
    endtask

    // groups of carry set, arith, adc or sbc, free pick or jmp, store
    task automatic build_program();
        logic [15:0] at;
        logic [15:0] target;
        logic [7:0]  op;
        int          g;
        int          s;
        int          mode;
        int          i;
        for (i = 0; i < 65536; i++) mem[i] = fill_byte(i[15:0]);
        mem[`CPU_RST_VECTOR] = PROG_BASE[7:0];
        mem[`CPU_RST_VECTOR + 1] = PROG_BASE[15:8];
        at = PROG_BASE;
        for (g = 0; g < N_GROUPS; g++) begin
            for (s = 0; s < 5; s++) begin
                case (s)
                    0: op = take_bits(1) ? 8'h38 : 8'h18;
                    1: op = ARITH_OPS[(take_bits(4) % 9) * 8 +: 8];
                    2: op = ARITH_OPS[(take_bits(3) % 6) * 8 +: 8];
                    3: op = g[0] ? 8'h4C : ANY_OPS[(take_bits(8) % 44) * 8 +: 8];
                    default: op = STORE_OPS[(take_bits(3) % 6) * 8 +: 8];
                endcase
                mem[at] = op;
                mode = addr_mode(op);
                if (op == 8'h4C) begin
                    target = at + 16'd3 + 16'(take_bits(3));  // skipped bytes keep the fill
                    mem[at + 16'd1] = target[7:0];
                    mem[at + 16'd2] = target[15:8];
                    at = target;
                end else begin
                    if (mode != 0) mem[at + 16'd1] = take_bits(8);
                    if (mode == 3) mem[at + 16'd2] = 8'h02;   // data page 02xx
                    at = at + 16'((mode == 0) ? 1 : (mode == 3) ? 3 : 2);
                end
            end
        end
        mem[at] = 8'h02;   // undefined opcode ends the program
        for (i = 0; i < 65536; i++) ref_mem[i] = mem[i];
    endtask

    task automatic queue_store(input logic [15:0] addr, input logic [7:0] val);
        ref_mem[addr] = val;
        wr_addr = addr;
        wr_data = val;
        wr_pending = 1'b1;
    endtask

    // one instruction at its opcode fetch
    task automatic step_model();
        logic [7:0]  op;
        logic [7:0]  lo;
        logic [7:0]  hi;
        logic [7:0]  m;
        logic [8:0]  sum;
        logic [15:0] ea;
        int          mode;
        op = ref_mem[m_pc];
        lo = ref_mem[m_pc + 16'd1];
        hi = ref_mem[m_pc + 16'd2];
        mode = addr_mode(op);
        ea = (mode == 3) ? {hi, lo} : {8'h00, lo};
        m = (mode == 1) ? lo : ref_mem[ea];
        exp_gap = (mode < 2) ? 2 : mode + 1;
        m_pc = m_pc + 16'((mode == 0) ? 1 : (mode == 3) ? 3 : 2);
        case (op)
            8'hA9, 8'hA5, 8'hAD: m_a = m;
            8'hA2, 8'hA6, 8'hAE: m_x = m;
            8'hA0, 8'hA4, 8'hAC: m_y = m;
            8'h09, 8'h05, 8'h0D: m_a = m_a | m;
            8'h29, 8'h25, 8'h2D: m_a = m_a & m;
            8'h49, 8'h45, 8'h4D: m_a = m_a ^ m;
            8'h69, 8'h65, 8'h6D: begin
                sum = {1'b0, m_a} + {1'b0, m} + {8'd0, m_c};
                {m_c, m_a} = sum;
            end
            8'hE9, 8'hE5, 8'hED: begin   // borrow is the inverted carry
                sum = {1'b0, m_a} + {1'b0, ~m} + {8'd0, m_c};
                {m_c, m_a} = sum;
            end
            8'hC9, 8'hC5, 8'hCD: m_c = (m_a >= m);
            8'h85, 8'h8D: queue_store(ea, m_a);
            8'h86, 8'h8E: queue_store(ea, m_x);
            8'h84, 8'h8C: queue_store(ea, m_y);
            8'hE8: m_x = m_x + 8'd1;
            8'hC8: m_y = m_y + 8'd1;
            8'hCA: m_x = m_x - 8'd1;
            8'h88: m_y = m_y - 8'd1;
            8'hAA: m_x = m_a;
            8'h8A: m_a = m_x;
            8'hA8: m_y = m_a;
            8'h98: m_a = m_y;
            8'h18: m_c = 1'b0;
            8'h38: m_c = 1'b1;
            8'hEA: begin end
            8'h4C: begin
                m_pc = {hi, lo};
                exp_gap = 3;
            end
            default: jam_expected = 1'b1;
        endcase
    endtask

    initial begin
        i_rst = 1'b1;
        i_data = 8'h00;
        lfsr = SEED;
        build_program();
        m_a = 8'h00;
        m_x = 8'h00;
        m_y = 8'h00;
        m_c = 1'b0;
        m_pc = {ref_mem[`CPU_RST_VECTOR + 1], ref_mem[`CPU_RST_VECTOR]};
        repeat (3) @(posedge i_clk);
        i_rst <= 1'b0;
    end

    // outputs are settled at the falling edge
    always @(negedge i_clk) begin
        cycles++;
        require_true(cycles < MAX_CYCLES, "timeout before the core reached the jam state");
        require_true(DUT.u_sva.err_count == 0, "a bound assertion on the core strobes failed");
        if (!i_rst) begin
            if (boot_cyc < 2) begin
                compare_value("boot address", `CPU_RST_VECTOR + 16'(boot_cyc), o_addr);
                compare_value("boot sync", 16'd0, 16'(o_sync));
                boot_cyc++;
            end else begin
                gap++;
                if (!seen_sync) compare_value("first sync", 16'd1, 16'(o_sync));
                if (o_rw !== 1'b1) begin
                    require_true(wr_pending, "memory write with no store in flight");
                    compare_value("store address", wr_addr, o_addr);
                    compare_value("store data", 16'(wr_data), 16'(o_dout));
                    wr_pending = 1'b0;
                end
                if (o_jam) begin
                    require_true(jam_expected, "jam raised on a defined opcode");
                    jam_cycles++;
                end
                if (o_sync) begin
                    require_true(!jam_expected, "opcode fetch after the undefined opcode");
                    require_true(!wr_pending, "store never reached the bus");
                    compare_value("sync address", m_pc, o_addr);
                    if (seen_sync) compare_value("sync spacing", 16'(exp_gap), 16'(gap));
                    seen_sync = 1'b1;
                    gap = 0;
                    step_model();
                end
                if (jam_cycles == JAM_HOLD) begin
                    $display("sim passed");
                    $finish;
                end
            end
        end
    end

endmodule

// ==== project.f ====
+incdir+logic
logic/cpu_pkg.sv
logic/cpu_decode.sv
logic/cpu_sequencer.sv
logic/cpu_regfile.sv
logic/cpu_alu.sv
logic/cpu_addr_gen.sv
logic/cpu_core.sv
test/cpu_sva.sv
test/tb_cpu.sv

// ==== Bender.yml ====
package:
  name: cpu_core

sources:
  - include_dirs:
      - logic
    files:
      - logic/cpu_pkg.sv
      - logic/cpu_decode.sv
      - logic/cpu_sequencer.sv
      - logic/cpu_regfile.sv
      - logic/cpu_alu.sv
      - logic/cpu_addr_gen.sv
      - logic/cpu_core.sv
  - target: test
    include_dirs:
      - logic
    files:
      - test/cpu_sva.sv
      - test/tb_cpu.sv
